/* build.f */
gfx_pkg.sv
gfx_pattern_gen.sv
gfx_pixel_fifo.sv
vga_scanout.sv
gfx_pattern_top.sv
tb_gfx_pattern_top.sv

/* gfx_pattern_gen.sv */
// writes one frame of stripes in raster order; a pause on pattern_en is not caught up
`timescale 1ns/1ps

module gfx_pattern_gen (
  input  logic            pixel_clk,
  input  logic            rst_n,
  input  logic            pattern_en,
  input  logic            full,
  output logic            wr_en,
  output gfx_pkg::pixel_t wr_data
);
  import gfx_pkg::*;

  coord_t x;
  coord_t y;
  logic   x_last;
  logic   y_last;

  // write whenever there is room and the pattern is enabled
  assign wr_en = pattern_en && !full;

  assign x_last = (x == X_LAST);
  assign y_last = (y == Y_LAST);

  // stripes are 64 pixels wide, so red is x / 64
  assign wr_data.red = x[9:6];

  // horizontal bands 32 lines high
  assign wr_data.grn = y[8:5];

  assign wr_data.blu = wr_data.red ^ wr_data.grn;

  // raster position only moves on an accepted write
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else if (wr_en) begin
      if (x_last) begin
        x <= '0;
        if (y_last) begin
          y <= '0;
        end else begin
          y <= y + 10'd1;
        end
      end else begin
        x <= x + 10'd1;
      end
    end
  end

endmodule

/* gfx_pattern_top.sv */
// single pixel_clk domain; once an underflow happens only a reset realigns producer and scanout
`timescale 1ns/1ps

module gfx_pattern_top (
  input  logic               pixel_clk,
  input  logic               rst_n,
  input  logic               pattern_en,
  output gfx_pkg::color_t    red,
  output gfx_pkg::color_t    grn,
  output gfx_pkg::color_t    blu,
  output logic               hsync,
  output logic               vsync,
  output gfx_pkg::err_count_t error_count
);
  import gfx_pkg::*;

  logic   wr_en;
  pixel_t wr_data;
  logic   rd_en;
  pixel_t rd_data;
  logic   full;
  logic   empty;
  logic   vga_error;

  gfx_pattern_gen gfx_pattern_gen_i (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .pattern_en(pattern_en),
    .full      (full),
    .wr_en     (wr_en),
    .wr_data   (wr_data)
  );

  gfx_pixel_fifo gfx_pixel_fifo_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty)
  );

  vga_scanout vga_scanout_i (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .rd_data  (rd_data),
    .empty    (empty),
    .rd_en    (rd_en),
    .red      (red),
    .grn      (grn),
    .blu      (blu),
    .hsync    (hsync),
    .vsync    (vsync),
    .error    (vga_error)
  );

  // underflow count, held at the ceiling once reached
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      error_count <= '0;
    end else if (vga_error && (error_count != ERR_COUNT_MAX)) begin
      error_count <= error_count + 16'd1;
    end
  end

endmodule

/* gfx_pixel_fifo.sv */
// first-word-fall-through; writer must respect full and reader must respect empty
`timescale 1ns/1ps

module gfx_pixel_fifo (
  input  logic            pixel_clk,
  input  logic            rst_n,
  input  logic            wr_en,
  input  gfx_pkg::pixel_t wr_data,
  input  logic            rd_en,
  output gfx_pkg::pixel_t rd_data,
  output logic            full,
  output logic            empty
);
  import gfx_pkg::*;

  pixel_t    mem [FIFO_DEPTH];
  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_cnt_t count;

  // oldest entry is always on the read port
  assign rd_data = mem[rd_ptr];

  assign full  = (count == FIFO_FULL);
  assign empty = (count == '0);

  // storage
  always_ff @(posedge pixel_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producer side must hold off while full
  a_no_overflow : assert property (
    @(posedge pixel_clk) disable iff (!rst_n)
      !(wr_en && full)
  ) else $error("pixel FIFO written while full");

  // consumer side must hold off while empty
  a_no_underflow : assert property (
    @(posedge pixel_clk) disable iff (!rst_n)
      !(rd_en && empty)
  ) else $error("pixel FIFO read while empty");

endmodule

/* gfx_pkg.sv */
// fixed 640x480 at 60 Hz mode only; FIFO_DEPTH must be a power of two for pointer wrap
package gfx_pkg;

  // one colour channel of the 12-bit output
  typedef logic [3:0] color_t;

  // pixel or line position, wide enough for the 800 pixel total
  typedef logic [9:0] coord_t;

  // saturating underflow counter value
  typedef logic [15:0] err_count_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } pixel_t;

  // horizontal timing in pixels
  localparam coord_t H_VISIBLE = 10'd640;
  localparam coord_t H_FRONT   = 10'd16;
  localparam coord_t H_SYNC    = 10'd96;
  localparam coord_t H_TOTAL   = 10'd800;

  // vertical timing in lines
  localparam coord_t V_VISIBLE = 10'd480;
  localparam coord_t V_FRONT   = 10'd10;
  localparam coord_t V_SYNC    = 10'd2;
  localparam coord_t V_TOTAL   = 10'd525;

  // derived positions used by the counters and the sync decode
  localparam coord_t H_LAST       = H_TOTAL - 10'd1;
  localparam coord_t V_LAST       = V_TOTAL - 10'd1;
  localparam coord_t X_LAST       = H_VISIBLE - 10'd1;
  localparam coord_t Y_LAST       = V_VISIBLE - 10'd1;
  localparam coord_t H_SYNC_START = H_VISIBLE + H_FRONT;
  localparam coord_t H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam coord_t V_SYNC_START = V_VISIBLE + V_FRONT;
  localparam coord_t V_SYNC_END   = V_SYNC_START + V_SYNC;

  // pixel FIFO sizing
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  // one extra bit so a full FIFO can be told apart from an empty one
  typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

  localparam fifo_cnt_t FIFO_FULL = fifo_cnt_t'(FIFO_DEPTH);

  // error counter ceiling
  localparam err_count_t ERR_COUNT_MAX = '1;

endpackage

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and decide the result from the simulation log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_gfx_pattern_top

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f build.f -o "sim_$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./obj_dir/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

/* tb_gfx_pattern_top.sv */
// runs about two frames at a 20 ns pixel clock; reads the internal underflow pulse through dut_i
`timescale 1ns/1ps

module tb_gfx_pattern_top;
  import gfx_pkg::*;

  // what the monitor expects on the video pins for one position
  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
    logic   hsync;
    logic   vsync;
  } vga_out_t;

  localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
  localparam int LINE_CYCLES  = int'(H_TOTAL);
  localparam int DROP_CYCLES  = 40;

  logic       pixel_clk;
  logic       rst_n;
  logic       pattern_en;
  color_t     red;
  color_t     grn;
  color_t     blu;
  logic       hsync;
  logic       vsync;
  err_count_t error_count;

  // model of the scanout counter and the position now on the outputs
  logic   started = 1'b0;
  coord_t cnt_h;
  coord_t cnt_v;
  coord_t shown_h;
  coord_t shown_v;

  logic        colour_check;
  int          col_hits;
  int          row_hits;
  int          flagged;
  coord_t      drop_x;

  gfx_pattern_top dut_i (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .pattern_en (pattern_en),
    .red        (red),
    .grn        (grn),
    .blu        (blu),
    .hsync      (hsync),
    .vsync      (vsync),
    .error_count(error_count)
  );

  initial pixel_clk = 1'b0;
  always #10 pixel_clk = ~pixel_clk;

  function automatic vga_out_t expected_out(input coord_t h, input coord_t v);
    vga_out_t o;
    o = '0;
    if ((h < H_VISIBLE) && (v < V_VISIBLE)) begin
      // 64 pixel wide columns, 32 line high bands
      o.red = color_t'(h / 64);
      o.grn = color_t'(v / 32);
      o.blu = o.red ^ o.grn;
    end
    o.hsync = !((h >= H_VISIBLE + H_FRONT) && (h < H_VISIBLE + H_FRONT + H_SYNC));
    o.vsync = !((v >= V_VISIBLE + V_FRONT) && (v < V_VISIBLE + V_FRONT + V_SYNC));
    return o;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h (x %0d, y %0d)",
               $time, what, got, exp, shown_h, shown_v);
      $display("** FAIL **");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t ns waiting for %s", $time, what);
    $display("** FAIL **");
    $fatal(1, "stopped on a timeout");
  endtask

  // the counter model steps on every edge that sees rst_n high
  always @(posedge pixel_clk) begin
    if (!rst_n) begin
      started <= 1'b0;
      cnt_h   <= '0;
      cnt_v   <= V_TOTAL - 10'd1;
    end else begin
      started <= 1'b1;
      shown_h <= cnt_h;
      shown_v <= cnt_v;
      if (cnt_h == H_TOTAL - 10'd1) begin
        cnt_h <= '0;
        cnt_v <= (cnt_v == V_TOTAL - 10'd1) ? 10'd0 : cnt_v + 10'd1;
      end else begin
        cnt_h <= cnt_h + 10'd1;
      end
    end
  end

  // compare on the falling edge, half a cycle clear of the registers
  always @(negedge pixel_clk) begin : compare_outputs
    vga_out_t exp;
    if (!rst_n) begin
      col_hits = 0;
      row_hits = 0;
      flagged  = 0;
    end else if (started) begin
      exp = expected_out(shown_h, shown_v);
      check_value("hsync", hsync, exp.hsync);
      check_value("vsync", vsync, exp.vsync);
      // counter lags the pulse by one edge
      check_value("error_count", error_count, flagged);
      if (colour_check) begin
        check_value("red", red, exp.red);
        check_value("grn", grn, exp.grn);
        check_value("blu", blu, exp.blu);
        check_value("underflow pulse", dut_i.vga_error, 0);
        if (shown_v < V_VISIBLE) begin
          // stripe edges against literal values
          case (shown_h)
            10'd63:  check_value("red at x 63", red, 0);
            10'd64:  check_value("red at x 64", red, 1);
            10'd575: check_value("red at x 575", red, 8);
            10'd576: check_value("red at x 576", red, 9);
            default: ;
          endcase
          if ((shown_h == 10'd63) || (shown_h == 10'd64) ||
              (shown_h == 10'd575) || (shown_h == 10'd576)) begin
            col_hits++;
          end
          if (shown_h == 10'd0) begin
            case (shown_v)
              10'd31:  check_value("grn at y 31", grn, 0);
              10'd32:  check_value("grn at y 32", grn, 1);
              10'd479: check_value("grn at y 479", grn, 14);
              default: ;
            endcase
            if ((shown_v == 10'd31) || (shown_v == 10'd32) || (shown_v == 10'd479)) begin
              row_hits++;
            end
          end
        end
      end else if (dut_i.vga_error) begin
        check_value("red on underflow", red, 0);
        check_value("grn on underflow", grn, 0);
        check_value("blu on underflow", blu, 0);
      end
      if (dut_i.vga_error) begin
        flagged++;
      end
    end
  end

  task automatic apply_reset();
    @(posedge pixel_clk);
    #1;
    rst_n        = 1'b0;
    pattern_en   = 1'b1;
    colour_check = 1'b1;
    repeat (8) @(posedge pixel_clk);
    #1;
    rst_n = 1'b1;
    // still ahead of the first edge that sees rst_n high
    @(negedge pixel_clk);
    check_value("hsync out of reset", hsync, 1);
    check_value("vsync out of reset", vsync, 1);
    check_value("red out of reset", red, 0);
    check_value("grn out of reset", grn, 0);
    check_value("blu out of reset", blu, 0);
    check_value("error_count out of reset", error_count, 0);
  endtask

  task automatic wait_shown(input coord_t h, input coord_t v, input int limit,
                            input string what);
    int n;
    n = 0;
    @(negedge pixel_clk);
    while (!(started && (shown_h == h) && (shown_v == v))) begin
      if (n >= limit) begin
        report_timeout(what);
      end
      n++;
      @(negedge pixel_clk);
    end
  endtask

  task automatic wait_error_count(input int limit);
    int n;
    n = 0;
    while (error_count == '0) begin
      if (n >= limit) begin
        report_timeout("error_count to rise above zero");
      end
      n++;
      @(negedge pixel_clk);
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    pattern_en   = 1'b1;
    colour_check = 1'b1;
    void'($urandom(15));

    // one whole frame plus the start of the next
    apply_reset();
    wait_shown(10'd0, 10'd0, 2 * LINE_CYCLES, "first visible pixel");
    wait_shown(10'd0, V_TOTAL - 10'd1, FRAME_CYCLES, "end of the first frame");
    check_value("column boundary pixels seen", col_hits, 4 * int'(V_VISIBLE));
    check_value("row boundary pixels seen", row_hits, 3);
    wait_shown(10'd0, 10'd2, 3 * LINE_CYCLES, "start of the second frame");
    $display("frame and stripe boundaries checked");

    // dropout on the second line
    apply_reset();
    // below 600 the FIFO drains before the line ends, so underflows must follow
    drop_x = coord_t'($urandom % 600);
    wait_shown(drop_x, 10'd1, 3 * LINE_CYCLES, "dropout pixel on the second line");
    @(posedge pixel_clk);
    #1;
    colour_check = 1'b0;
    pattern_en   = 1'b0;
    repeat (DROP_CYCLES) @(posedge pixel_clk);
    #1;
    pattern_en = 1'b1;
    wait_error_count(2 * LINE_CYCLES);
    $display("underflow seen after a dropout at x %0d, count %0d", drop_x, error_count);

    // recovery needs a reset
    apply_reset();
    wait_shown(10'd0, 10'd0, 2 * LINE_CYCLES, "first visible pixel after recovery");
    wait_shown(10'd0, 10'd1, 2 * LINE_CYCLES, "end of the first visible line");
    check_value("error_count after recovery", error_count, 0);

    $display("** PASS **");
    $finish;
  end

endmodule

/* vga_scanout.sv */
// outputs lag the counters by one cycle; the first line after reset is blank while the FIFO fills
`timescale 1ns/1ps

module vga_scanout (
  input  logic            pixel_clk,
  input  logic            rst_n,
  input  gfx_pkg::pixel_t rd_data,
  input  logic            empty,
  output logic            rd_en,
  output gfx_pkg::color_t red,
  output gfx_pkg::color_t grn,
  output gfx_pkg::color_t blu,
  output logic            hsync,
  output logic            vsync,
  output logic            error
);
  import gfx_pkg::*;

  coord_t h_cnt;
  coord_t v_cnt;
  logic   h_last;
  logic   v_last;
  logic   visible;
  logic   hsync_win;
  logic   vsync_win;
  logic   underflow;

  assign h_last = (h_cnt == H_LAST);
  assign v_last = (v_cnt == V_LAST);

  // horizontal and vertical counters
  // start on the last line so the FIFO gets a full blank line to fill
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= V_LAST;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        if (v_last) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 10'd1;
        end
      end else begin
        h_cnt <= h_cnt + 10'd1;
      end
    end
  end

  // region decode
  assign visible = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);

  assign hsync_win = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
  assign vsync_win = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

  // one pop per visible pixel, but only if there is something to pop
  assign rd_en = visible && !empty;

  // nothing to show at a visible pixel
  assign underflow = visible && empty;

  // registered outputs
  // syncs are active low and idle high out of reset
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      red   <= '0;
      grn   <= '0;
      blu   <= '0;
      hsync <= 1'b1;
      vsync <= 1'b1;
      error <= 1'b0;
    end else begin
      if (rd_en) begin
        red <= rd_data.red;
        grn <= rd_data.grn;
        blu <= rd_data.blu;
      end else begin
        // blanking and underflow both show black
        red <= '0;
        grn <= '0;
        blu <= '0;
      end
      hsync <= !hsync_win;
      vsync <= !vsync_win;
      error <= underflow;
    end
  end

  a_cnt_range : assert property (
    @(posedge pixel_clk) disable iff (!rst_n)
      (h_cnt < H_TOTAL) && (v_cnt < V_TOTAL)
  ) else $error("scanout counter past the frame total");

endmodule
